/* build.f */
common/simmem_pkg.sv
linkedlist/ram_2p.sv
linkedlist/free_slot_tracker.sv
linkedlist/list_ctrl.sv
linkedlist/simmem_linkedlist_bank.sv
test/linkedlist_bank_props.sv
test/tb_linkedlist_bank.sv

/* test/tb_linkedlist_bank.sv */
/*
 * Directed testbench for the linked-list message bank.
 * A queue per identifier models the bank, and every cycle's outputs are
 * compared with it. Run from the project root with build.f.
 */

`timescale 1ns/100ps

module tb_linkedlist_bank;

  localparam int RAND_STEPS = 300;
  // Cycle budget per test in run order, then the margin
  localparam int TIMEOUT_CYCLES = 4 + 4 + 12 + (RAND_STEPS + 24) + 40 + 4 + 8 + 200;

  logic                                 clk_i;
  logic                                 rst_ni;
  logic                                 in_valid_i;
  simmem_pkg::id_t                      in_id_i;
  simmem_pkg::payload_t                 in_data_i;
  logic                                 in_ready_o;
  logic [simmem_pkg::NUM_IDS-1:0]       release_onehot_i;
  logic [simmem_pkg::NUM_IDS-1:0]       buf_valid_o;
  simmem_pkg::payload_t                 buf_data_o [simmem_pkg::NUM_IDS];

  // Reference model with one queue of accepted messages per identifier
  simmem_pkg::payload_t                 model_q [simmem_pkg::NUM_IDS][$];

  // Outputs as sampled in the last cycle
  logic                                 last_ready;
  logic [simmem_pkg::NUM_IDS-1:0]       last_valid;
  simmem_pkg::payload_t                 last_data [simmem_pkg::NUM_IDS];

  int checks;
  int errors;
  int cycle_cnt;

  simmem_linkedlist_bank UUT (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .in_valid_i       (in_valid_i),
    .in_id_i          (in_id_i),
    .in_data_i        (in_data_i),
    .in_ready_o       (in_ready_o),
    .release_onehot_i (release_onehot_i),
    .buf_valid_o      (buf_valid_o),
    .buf_data_o       (buf_data_o)
  );

  always #2 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, the tests did not complete", cycle_cnt);
      $display("Simulation FAILED");
      $finish;
    end
  end

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  // Count of queued messages that sit in RAM behind the buffered heads
  function automatic int ram_count();
    int n;
    n = 0;
    for (int k = 0; k < simmem_pkg::NUM_IDS; k++) begin
      if (model_q[k].size() != 0) begin
        n += model_q[k].size() - 1;
      end
    end
    return n;
  endfunction

  // Drive on the falling edge, check mid-cycle and update the model at the rising edge
  task automatic step(input logic valid, input simmem_pkg::id_t id,
                      input simmem_pkg::payload_t data,
                      input logic [simmem_pkg::NUM_IDS-1:0] rel);
    logic                 accepted;
    logic                 exp_valid;
    simmem_pkg::payload_t exp_data;
    @(negedge clk_i);
    in_valid_i = valid;
    in_id_i = id;
    in_data_i = data;
    release_onehot_i = rel;
    #1;
    last_ready = in_ready_o;
    last_valid = buf_valid_o;
    last_data = buf_data_o;
    accepted = valid && in_ready_o;
    check_val("in_ready_o", in_ready_o, ram_count() < simmem_pkg::CAPACITY);
    for (int k = 0; k < simmem_pkg::NUM_IDS; k++) begin
      exp_valid = (model_q[k].size() != 0) || (accepted && id == simmem_pkg::id_t'(k));
      exp_data = (model_q[k].size() != 0) ? model_q[k][0] : data;
      check_val($sformatf("buf_valid_o[%0d]", k), buf_valid_o[k], exp_valid);
      if (exp_valid) begin
        check_val($sformatf("buf_data_o[%0d]", k), buf_data_o[k], exp_data);
      end
    end
    @(posedge clk_i);
    if (accepted) begin
      model_q[id].push_back(data);
    end
    for (int k = 0; k < simmem_pkg::NUM_IDS; k++) begin
      if (rel[k] && model_q[k].size() != 0) begin
        void'(model_q[k].pop_front());
      end
    end
  endtask

  // Release the lowest busy identifier until every queue is empty
  task automatic drain();
    logic [simmem_pkg::NUM_IDS-1:0] rel;
    do begin
      rel = '0;
      for (int k = 0; k < simmem_pkg::NUM_IDS; k++) begin
        if (rel == '0 && model_q[k].size() != 0) begin
          rel[k] = 1'b1;
        end
      end
      step(1'b0, '0, '0, rel);
    end while (rel != '0);
  endtask

  task automatic reset_state();
    step(1'b0, '0, '0, '0);
    check_val("buf_valid_o", last_valid, '0);
    check_val("in_ready_o", last_ready, 1'b1);
  endtask

  task automatic direct_fill();
    for (int k = 0; k < simmem_pkg::NUM_IDS; k++) begin
      step(1'b1, simmem_pkg::id_t'(k), simmem_pkg::payload_t'(8'hA0 + k), '0);
      check_val($sformatf("buf_valid_o[%0d]", k), last_valid[k], 1'b1);
    end
    step(1'b0, '0, '0, '0);
    drain();
  endtask

  task automatic random_fifo();
    logic [simmem_pkg::NUM_IDS-1:0] rel;
    int                             pick;
    for (int n = 0; n < RAND_STEPS; n++) begin
      // A pick of NUM_IDS means no release in this cycle
      pick = $urandom_range(simmem_pkg::NUM_IDS, 0);
      rel = '0;
      if (pick < simmem_pkg::NUM_IDS && model_q[pick].size() != 0) begin
        rel[pick] = 1'b1;
      end
      step($urandom_range(4, 0) < 3, simmem_pkg::id_t'($urandom_range(3, 0)),
           simmem_pkg::payload_t'($urandom), rel);
    end
    drain();
  endtask

  task automatic full_bank();
    for (int n = 0; n < simmem_pkg::CAPACITY + 1; n++) begin
      step(1'b1, 2'd3, simmem_pkg::payload_t'(8'h40 + n), '0);
      check_val("in_ready_o", last_ready, 1'b1);
    end
    step(1'b1, 2'd3, 8'hEE, '0);
    check_val("in_ready_o", last_ready, 1'b0);
    step(1'b0, 2'd3, '0, 4'b1000);
    step(1'b0, '0, '0, '0);
    check_val("in_ready_o", last_ready, 1'b1);
    check_val("buf_data_o[3]", last_data[3], 8'h41);
    drain();
  endtask

  task automatic pass_through();
    step(1'b1, 2'd1, 8'h5A, 4'b0010);
    check_val("buf_valid_o[1]", last_valid[1], 1'b1);
    check_val("buf_data_o[1]", last_data[1], 8'h5A);
    step(1'b0, '0, '0, '0);
    check_val("buf_valid_o[1]", last_valid[1], 1'b0);
  endtask

  // Accept and release together while one message waits in RAM
  task automatic one_entry_refill();
    simmem_pkg::payload_t sent [3];
    sent = '{8'h11, 8'h22, 8'h33};
    step(1'b1, 2'd2, sent[0], '0);
    step(1'b1, 2'd2, sent[1], '0);
    step(1'b1, 2'd2, sent[2], 4'b0100);
    check_val("released buf_data_o[2]", last_data[2], sent[0]);
    step(1'b0, '0, '0, 4'b0100);
    check_val("released buf_data_o[2]", last_data[2], sent[1]);
    step(1'b0, '0, '0, 4'b0100);
    check_val("released buf_data_o[2]", last_data[2], sent[2]);
    step(1'b0, '0, '0, '0);
    check_val("buf_valid_o[2]", last_valid[2], 1'b0);
  endtask

  initial begin
    void'($urandom(79));
    checks = 0;
    errors = 0;
    cycle_cnt = 0;
    clk_i = 1'b0;
    rst_ni = 1'b0;
    in_valid_i = 1'b0;
    in_id_i = '0;
    in_data_i = '0;
    release_onehot_i = '0;
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    reset_state();
    direct_fill();
    random_fifo();
    full_bank();
    pass_through();
    one_entry_refill();

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

/* test/linkedlist_bank_props.sv */
/*
 * Concurrent checks on the message bank, bound to its top level.
 * Watches the release strobe and the ready flag against the pool's valid bits.
 */

`timescale 1ns/100ps

module linkedlist_bank_props (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic [simmem_pkg::NUM_IDS-1:0]  release_onehot_i,
  input  logic                            in_ready_i,
  input  logic [simmem_pkg::CAPACITY-1:0] valid_bits_i
);

  // At most one identifier released per cycle
  release_onehot_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni) $onehot0(release_onehot_i)
  ) else $error("Release strobe has more than one bit set");

  // Ready drops only when every pool entry is taken
  ready_low_full_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni) !in_ready_i |-> &valid_bits_i
  ) else $error("Input not ready although a pool entry is free");

endmodule

bind simmem_linkedlist_bank linkedlist_bank_props u_props (
  .clk_i            (clk_i),
  .rst_ni           (rst_ni),
  .release_onehot_i (release_onehot_i),
  .in_ready_i       (in_ready_o),
  .valid_bits_i     (u_free_slot_tracker.valid_q)
);

/* linkedlist/simmem_linkedlist_bank.sv */
/*
 * Linked-list message bank. Messages share one pool of entries, each
 * identifier keeps its own FIFO list and shows its oldest message in an
 * output buffer until it is released.
 */

`timescale 1ns/100ps

module simmem_linkedlist_bank (
  input  logic                           clk_i,
  input  logic                           rst_ni,

  input  logic                           in_valid_i,
  input  simmem_pkg::id_t                in_id_i,
  input  simmem_pkg::payload_t           in_data_i,
  output logic                           in_ready_o,

  input  logic [simmem_pkg::NUM_IDS-1:0] release_onehot_i,
  output logic [simmem_pkg::NUM_IDS-1:0] buf_valid_o,
  output simmem_pkg::payload_t           buf_data_o [simmem_pkg::NUM_IDS]
);

  // Free entry search
  logic                 any_free;
  simmem_pkg::addr_t    free_entry;
  logic                 alloc;
  logic                 free_req;
  simmem_pkg::addr_t    free_head;

  // RAM ports
  logic                 wr_req;
  simmem_pkg::addr_t    wr_addr;
  simmem_pkg::payload_t wr_data;
  simmem_pkg::addr_t    ptr_wr_addr;
  logic                 rd_req;
  simmem_pkg::addr_t    rd_addr;
  simmem_pkg::payload_t rd_payload;
  simmem_pkg::addr_t    rd_next;

  assign in_ready_o = any_free;

  list_ctrl u_list_ctrl (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .in_valid_i       (in_valid_i),
    .in_id_i          (in_id_i),
    .in_data_i        (in_data_i),
    .any_free_i       (any_free),
    .free_addr_i      (free_entry),
    .release_onehot_i (release_onehot_i),
    .buf_valid_o      (buf_valid_o),
    .buf_data_o       (buf_data_o),
    .alloc_o          (alloc),
    .free_o           (free_req),
    .free_addr_o      (free_head),
    .wr_req_o         (wr_req),
    .wr_addr_o        (wr_addr),
    .wr_data_o        (wr_data),
    .ptr_wr_addr_o    (ptr_wr_addr),
    .rd_req_o         (rd_req),
    .rd_addr_o        (rd_addr),
    .rd_payload_i     (rd_payload),
    .rd_next_i        (rd_next)
  );

  free_slot_tracker u_free_slot_tracker (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .alloc_i     (alloc),
    .free_i      (free_req),
    .free_addr_i (free_head),
    .any_free_o  (any_free),
    .free_addr_o (free_entry)
  );

  // Message payloads, written at the free entry
  ram_2p #(
    .data_t (simmem_pkg::payload_t)
  ) payload_ram (
    .clk_i     (clk_i),
    .wr_en_i   (wr_req),
    .wr_addr_i (wr_addr),
    .wr_data_i (wr_data),
    .rd_en_i   (rd_req),
    .rd_addr_i (rd_addr),
    .rd_data_o (rd_payload)
  );

  // Next pointers, the old tail is linked to the free entry
  ram_2p #(
    .data_t (simmem_pkg::addr_t)
  ) next_ram (
    .clk_i     (clk_i),
    .wr_en_i   (wr_req),
    .wr_addr_i (ptr_wr_addr),
    .wr_data_i (free_entry),
    .rd_en_i   (rd_req),
    .rd_addr_i (rd_addr),
    .rd_data_o (rd_next)
  );

endmodule

/* linkedlist/list_ctrl.sv */
/*
 * Per-identifier list control of the message bank: heads, tails, lengths
 * and the one-entry output buffers. Issues the RAM writes for incoming
 * messages and the RAM reads that refill a buffer on release.
 */

`timescale 1ns/100ps

module list_ctrl (
  input  logic                                clk_i,
  input  logic                                rst_ni,

  input  logic                                in_valid_i,
  input  simmem_pkg::id_t                     in_id_i,
  input  simmem_pkg::payload_t                in_data_i,

  input  logic                                any_free_i,
  input  simmem_pkg::addr_t                   free_addr_i,

  input  logic [simmem_pkg::NUM_IDS-1:0]      release_onehot_i,
  output logic [simmem_pkg::NUM_IDS-1:0]      buf_valid_o,
  output simmem_pkg::payload_t                buf_data_o [simmem_pkg::NUM_IDS],

  output logic                                alloc_o,
  output logic                                free_o,
  output simmem_pkg::addr_t                   free_addr_o,

  output logic                                wr_req_o,
  output simmem_pkg::addr_t                   wr_addr_o,
  output simmem_pkg::payload_t                wr_data_o,
  output simmem_pkg::addr_t                   ptr_wr_addr_o,

  output logic                                rd_req_o,
  output simmem_pkg::addr_t                   rd_addr_o,
  input  simmem_pkg::payload_t                rd_payload_i,
  input  simmem_pkg::addr_t                   rd_next_i
);

  // One extra bit so that a single list can hold every pool entry
  typedef logic [simmem_pkg::ADDR_W:0] len_t;

  // List state
  simmem_pkg::addr_t head_q   [simmem_pkg::NUM_IDS];
  simmem_pkg::addr_t head_d   [simmem_pkg::NUM_IDS];
  simmem_pkg::addr_t head_cur [simmem_pkg::NUM_IDS];
  simmem_pkg::addr_t tail_q   [simmem_pkg::NUM_IDS];
  simmem_pkg::addr_t tail_d   [simmem_pkg::NUM_IDS];
  len_t              len_q    [simmem_pkg::NUM_IDS];
  len_t              len_d    [simmem_pkg::NUM_IDS];

  // Output buffers
  simmem_pkg::payload_t buf_q   [simmem_pkg::NUM_IDS];
  simmem_pkg::payload_t buf_d   [simmem_pkg::NUM_IDS];
  simmem_pkg::payload_t buf_cur [simmem_pkg::NUM_IDS];
  logic [simmem_pkg::NUM_IDS-1:0] buf_valid_q;
  logic [simmem_pkg::NUM_IDS-1:0] buf_valid_d;

  // Set in the cycle after a refill read, select the RAM read data
  logic [simmem_pkg::NUM_IDS-1:0] buf_refill_q;
  logic [simmem_pkg::NUM_IDS-1:0] buf_refill_d;
  logic [simmem_pkg::NUM_IDS-1:0] head_refill_q;
  logic [simmem_pkg::NUM_IDS-1:0] head_refill_d;

  logic                           accept;
  logic [simmem_pkg::NUM_IDS-1:0] acc_id;
  logic [simmem_pkg::NUM_IDS-1:0] rel_id;
  logic [simmem_pkg::NUM_IDS-1:0] list_nonempty;
  logic [simmem_pkg::NUM_IDS-1:0] to_ram;
  logic [simmem_pkg::NUM_IDS-1:0] new_list;

  assign accept = in_valid_i && any_free_i;

  for (genvar g = 0; g < simmem_pkg::NUM_IDS; g++) begin : gen_id
    assign acc_id[g] = accept && (in_id_i == simmem_pkg::id_t'(g));
    assign rel_id[g] = release_onehot_i[g] && buf_valid_q[g];
    assign list_nonempty[g] = (len_q[g] != '0);

    assign buf_cur[g] = buf_refill_q[g] ? rd_payload_i : buf_q[g];
    assign head_cur[g] = head_refill_q[g] ? rd_next_i : head_q[g];

    // An empty buffer shows an arriving message in the same cycle
    assign buf_valid_o[g] = buf_valid_q[g] | acc_id[g];
    assign buf_data_o[g] = buf_valid_q[g] ? buf_cur[g] : in_data_i;

    // Full buffer sends the message to RAM, unless a release with an
    // empty list lets the buffer take it directly
    assign to_ram[g] = acc_id[g] && buf_valid_q[g] && !(rel_id[g] && !list_nonempty[g]);
    assign new_list[g] = (len_q[g] == '0) ||
                         (len_q[g] == len_t'(1) && release_onehot_i[g]);
  end

  always_comb begin
    for (int i = 0; i < simmem_pkg::NUM_IDS; i++) begin
      head_d[i] = head_cur[i];
      tail_d[i] = tail_q[i];
      len_d[i] = len_q[i];
      buf_d[i] = buf_cur[i];
      buf_valid_d[i] = buf_valid_q[i];
      buf_refill_d[i] = 1'b0;
      head_refill_d[i] = 1'b0;

      // Release of the shown message
      if (rel_id[i]) begin
        if (list_nonempty[i]) begin
          buf_refill_d[i] = 1'b1;
          head_refill_d[i] = 1'b1;
          len_d[i] = len_q[i] - len_t'(1);
        end else if (acc_id[i]) begin
          buf_d[i] = in_data_i;
        end else begin
          buf_valid_d[i] = 1'b0;
        end
      end

      // Empty buffer takes the message, or it passes through on release
      if (acc_id[i] && !buf_valid_q[i] && !release_onehot_i[i]) begin
        buf_d[i] = in_data_i;
        buf_valid_d[i] = 1'b1;
      end

      if (to_ram[i]) begin
        len_d[i] = len_d[i] + len_t'(1);
        tail_d[i] = free_addr_i;
        if (new_list[i]) begin
          // Head comes from the free entry, not from the stale pointer read
          head_d[i] = free_addr_i;
          head_refill_d[i] = 1'b0;
        end
      end
    end
  end

  // Write port, shared by the payload and pointer RAMs
  assign wr_req_o = |to_ram;
  assign wr_addr_o = free_addr_i;
  assign wr_data_o = in_data_i;
  assign alloc_o = wr_req_o;

  // A new list writes the pointer of its own entry so that no live entry is touched
  assign ptr_wr_addr_o = new_list[in_id_i] ? free_addr_i : tail_q[in_id_i];

  // Read the head of the released list; release is one-hot
  always_comb begin
    rd_req_o = 1'b0;
    rd_addr_o = '0;
    for (int i = 0; i < simmem_pkg::NUM_IDS; i++) begin
      if (rel_id[i] && list_nonempty[i]) begin
        rd_req_o = 1'b1;
        rd_addr_o = head_cur[i];
      end
    end
  end

  assign free_o = rd_req_o;
  assign free_addr_o = rd_addr_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < simmem_pkg::NUM_IDS; i++) begin
        head_q[i] <= '0;
        tail_q[i] <= '0;
        len_q[i] <= '0;
      end
      buf_valid_q <= '0;
      buf_refill_q <= '0;
      head_refill_q <= '0;
    end else begin
      for (int i = 0; i < simmem_pkg::NUM_IDS; i++) begin
        head_q[i] <= head_d[i];
        tail_q[i] <= tail_d[i];
        len_q[i] <= len_d[i];
      end
      buf_valid_q <= buf_valid_d;
      buf_refill_q <= buf_refill_d;
      head_refill_q <= head_refill_d;
    end
  end

  // Buffer payloads
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < simmem_pkg::NUM_IDS; i++) begin
      buf_q[i] <= buf_d[i];
    end
  end

endmodule

/* linkedlist/free_slot_tracker.sv */
/*
 * Tracks which pool entries hold a message and offers the lowest free one.
 * The offered entry is taken on alloc_i, a named entry is returned on free_i.
 */

`timescale 1ns/100ps

module free_slot_tracker (
  input  logic              clk_i,
  input  logic              rst_ni,

  input  logic              alloc_i,
  input  logic              free_i,
  input  simmem_pkg::addr_t free_addr_i,

  output logic              any_free_o,
  output simmem_pkg::addr_t free_addr_o
);

  // One bit per pool entry, set while the entry holds a message
  logic [simmem_pkg::CAPACITY-1:0] valid_q;
  logic [simmem_pkg::CAPACITY-1:0] valid_d;

  // Priority encoder, lowest clear bit wins
  always_comb begin
    free_addr_o = '0;
    for (int k = simmem_pkg::CAPACITY - 1; k >= 0; k--) begin
      if (!valid_q[k]) begin
        free_addr_o = simmem_pkg::addr_t'(k);
      end
    end
  end

  assign any_free_o = ~&valid_q;

  // Alloc and free never name the same entry, so both may apply at once
  always_comb begin
    valid_d = valid_q;
    if (alloc_i) begin
      valid_d[free_addr_o] = 1'b1;
    end
    if (free_i) begin
      valid_d[free_addr_i] = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else begin
      valid_q <= valid_d;
    end
  end

endmodule

/* linkedlist/ram_2p.sv */
/*
 * Two-port RAM with one write port and one registered read port.
 * Serves as payload store and as next-pointer store of the message bank.
 */

`timescale 1ns/100ps

module ram_2p #(
  parameter type data_t = simmem_pkg::payload_t
) (
  input  logic              clk_i,

  input  logic              wr_en_i,
  input  simmem_pkg::addr_t wr_addr_i,
  input  data_t             wr_data_i,

  input  logic              rd_en_i,
  input  simmem_pkg::addr_t rd_addr_i,
  output data_t             rd_data_o
);

  data_t mem_q [simmem_pkg::CAPACITY];

  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      mem_q[wr_addr_i] <= wr_data_i;
    end
  end

  // Read data appears one cycle after the request and then holds
  always_ff @(posedge clk_i) begin
    if (rd_en_i) begin
      rd_data_o <= mem_q[rd_addr_i];
    end
  end

endmodule

/* common/simmem_pkg.sv */
/*
 * Sizes and types shared by the linked-list message bank.
 * Modules refer to these by scoped name, e.g. simmem_pkg::addr_t.
 */

package simmem_pkg;

  // Number of message identifiers, each with its own list and output buffer
  localparam int NUM_IDS = 4;
  localparam int ID_W = 2;

  // Entries in the shared pool, common to all lists
  localparam int CAPACITY = 16;
  localparam int ADDR_W = 4;

  // Message payload width
  localparam int PAYLOAD_W = 8;

  // Message payload as stored in the payload RAM and the output buffers
  typedef logic [PAYLOAD_W-1:0] payload_t;

  // Index of a pool entry, also the content of the next-pointer RAM
  typedef logic [ADDR_W-1:0] addr_t;

  // Message identifier
  typedef logic [ID_W-1:0] id_t;

endpackage
